/* src/hist_pkg.sv */
`default_nettype none

package hist_pkg;

    // pixel array size
    localparam int pixel_num = 4;
    localparam int pixel_width = $clog2(pixel_num);

    // bins per histogram
    localparam int bin_num = 16;
    localparam int bin_width = $clog2(bin_num);

    // histogram memory, one entry per pixel and bin
    localparam int entry_num = pixel_num * bin_num;
    localparam int addr_width = pixel_width + bin_width;

    // raw tdc code and time window
    localparam int tdc_width = 8;
    // first code inside the window
    localparam int tdc_offset = 32;
    // 8 codes per bin, window ends before code 160
    localparam int bin_shift = 3;

    // saturating histogram count
    localparam int count_width = 8;

    // accepted hits per frame, above 255 so a bin can saturate
    localparam int events_per_frame = 300;
    localparam int frame_width = $clog2(events_per_frame + 1);

    // saturating counter of out-of-window hits
    localparam int drop_width = 16;

    // hit fifo between binner and builder
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    // binned hit
    typedef struct packed {
        logic [pixel_width-1:0] pixel;
        logic [bin_width-1:0]   bin;
    } hit_t;

endpackage

`default_nettype wire

/* src/tdc_binner.sv */
`default_nettype none
`timescale 1ns/1ps

module tdc_binner (
    input  wire logic                             clk,
    input  wire logic                             combin_res,
    input  wire logic                             in_valid,
    input  wire logic [hist_pkg::pixel_width-1:0] in_pixel,
    input  wire logic [hist_pkg::tdc_width-1:0]   in_code,
    output logic                                  in_ready,
    output logic                                  out_valid,
    input  wire logic                             out_ready,
    output hist_pkg::hit_t                        out_hit,
    output logic [hist_pkg::drop_width-1:0]       drop_count
);

    // code relative to window start
    logic [hist_pkg::tdc_width-1:0] rel_code;
    // bin index before the upper window check
    logic [hist_pkg::tdc_width-hist_pkg::bin_shift-1:0] rel_bin;
    logic below_window;
    logic in_window;
    logic take;

    assign rel_code = in_code - hist_pkg::tdc_width'(hist_pkg::tdc_offset);
    assign rel_bin = rel_code[hist_pkg::tdc_width-1:hist_pkg::bin_shift];

    // wraparound of rel_code only matters when below the window
    assign below_window = in_code < hist_pkg::tdc_width'(hist_pkg::tdc_offset);
    assign in_window = !below_window
        && (rel_bin < (hist_pkg::tdc_width - hist_pkg::bin_shift)'(hist_pkg::bin_num));

    // output register empty, or drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign take = in_valid && in_ready;

    // output stage valid flag
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            out_valid <= 1'b0;
        end else if (take) begin
            // dropped hits leave the stage empty
            out_valid <= in_window;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload, only loaded for in-window hits
    always_ff @(posedge clk) begin
        if (take && in_window) begin
            out_hit.pixel <= in_pixel;
            out_hit.bin <= rel_bin[hist_pkg::bin_width-1:0];
        end
    end

    // drop counter, sticks at all ones
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            drop_count <= '0;
        end else if (take && !in_window && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/hit_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module hit_fifo (
    input  wire logic           clk,
    input  wire logic           combin_res,
    input  wire logic           in_valid,
    output logic                in_ready,
    input  wire hist_pkg::hit_t in_hit,
    output logic                out_valid,
    input  wire logic           out_ready,
    output hist_pkg::hit_t      out_hit
);

    // circular buffer of binned hits
    hist_pkg::hit_t mem [hist_pkg::fifo_depth];

    logic [hist_pkg::fifo_ptr_width-1:0]   wr_ptr;
    logic [hist_pkg::fifo_ptr_width-1:0]   rd_ptr;
    logic [hist_pkg::fifo_count_width-1:0] count;
    logic full;
    logic wr_en;
    logic rd_en;

    assign full = count == hist_pkg::fifo_count_width'(hist_pkg::fifo_depth);

    // full fifo still takes a word when one leaves in the same cycle
    assign in_ready = !full || out_ready;
    assign out_valid = count != '0;

    // first word fall through
    assign out_hit = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_hit;
        end
    end

    // pointers wrap at depth
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                if (wr_ptr == hist_pkg::fifo_ptr_width'(hist_pkg::fifo_depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                if (rd_ptr == hist_pkg::fifo_ptr_width'(hist_pkg::fifo_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // occupancy stays put on a simultaneous read and write
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            count <= '0;
        end else if (wr_en && !rd_en) begin
            count <= count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/hist_builder.sv */
`default_nettype none
`timescale 1ns/1ps

module hist_builder (
    input  wire logic                              clk,
    input  wire logic                              combin_res,
    input  wire logic                              in_valid,
    output logic                                   in_ready,
    input  wire hist_pkg::hit_t                    in_hit,
    output logic                                   frame_ready,
    input  wire logic                              frame_ack,
    input  wire logic [hist_pkg::pixel_width-1:0]  rd_pixel,
    input  wire logic [hist_pkg::bin_width-1:0]    rd_bin,
    output logic [hist_pkg::count_width-1:0]       rd_count
);

    // two banks of counts that hold data only where the flag is set
    logic [hist_pkg::count_width-1:0] mem [2][hist_pkg::entry_num];
    // per bank written flags that a swap clears instead of the memory
    logic [1:0][hist_pkg::entry_num-1:0] written;

    // bank taking hits while the other one is held for readout
    logic bank_sel;
    // hits accepted into the active bank
    logic [hist_pkg::frame_width-1:0] frame_cnt;
    logic active_full;

    // write stage
    logic wr_vld;
    hist_pkg::hit_t wr_hit;
    logic [hist_pkg::addr_width-1:0] wr_addr;
    logic [hist_pkg::count_width-1:0] old_count;
    logic [hist_pkg::count_width-1:0] next_count;

    logic [hist_pkg::addr_width-1:0] rd_addr;
    logic accept;
    logic swap;

    assign active_full = frame_cnt == hist_pkg::frame_width'(hist_pkg::events_per_frame);

    // no hits taken from frame completion until the swap
    assign in_ready = !active_full;
    assign accept = in_valid && in_ready;

    // swap after the last write lands and the held bank is released
    assign swap = active_full && !wr_vld && !frame_ready;

    assign wr_addr = {wr_hit.pixel, wr_hit.bin};
    assign old_count = mem[bank_sel][wr_addr];

    // untouched entry starts at 1 and others increment with saturation
    always_comb begin
        if (!written[bank_sel][wr_addr]) begin
            next_count = hist_pkg::count_width'(1);
        end else if (old_count == '1) begin
            next_count = old_count;
        end else begin
            next_count = old_count + 1'b1;
        end
    end

    // register the accepted hit ahead of the memory update
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_hit <= in_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            mem[bank_sel][wr_addr] <= next_count;
        end
    end

    // frame control and flags
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wr_vld <= 1'b0;
            bank_sel <= 1'b0;
            frame_cnt <= '0;
            frame_ready <= 1'b0;
            written <= '0;
        end else begin
            wr_vld <= accept;
            if (accept) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (wr_vld) begin
                written[bank_sel][wr_addr] <= 1'b1;
            end
            if (swap) begin
                // old held bank becomes active with every entry empty
                bank_sel <= !bank_sel;
                written[!bank_sel] <= '0;
                frame_cnt <= '0;
                frame_ready <= 1'b1;
            end else if (frame_ack) begin
                frame_ready <= 1'b0;
            end
        end
    end

    // registered readout from the held bank
    assign rd_addr = {rd_pixel, rd_bin};

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_count <= '0;
        end else if (written[!bank_sel][rd_addr]) begin
            rd_count <= mem[!bank_sel][rd_addr];
        end else begin
            // no hit in this bin during the frame
            rd_count <= '0;
        end
    end

endmodule

`default_nettype wire

/* src/hist_top.sv */
`default_nettype none
`timescale 1ns/1ps

module hist_top (
    input  wire logic                             clk,
    input  wire logic                             combin_res,
    input  wire logic                             hit_valid,
    output logic                                  hit_ready,
    input  wire logic [hist_pkg::pixel_width-1:0] hit_pixel,
    input  wire logic [hist_pkg::tdc_width-1:0]   hit_code,
    output logic [hist_pkg::drop_width-1:0]       drop_count,
    output logic                                  frame_ready,
    input  wire logic                             frame_ack,
    input  wire logic [hist_pkg::pixel_width-1:0] rd_pixel,
    input  wire logic [hist_pkg::bin_width-1:0]   rd_bin,
    output logic [hist_pkg::count_width-1:0]      rd_count
);

    // binner to fifo
    logic           bin_valid;
    logic           bin_ready;
    hist_pkg::hit_t bin_hit;

    // fifo to builder
    logic           fifo_valid;
    logic           fifo_ready;
    hist_pkg::hit_t fifo_hit;

    tdc_binner binner_i (
        .clk        (clk),
        .combin_res (combin_res),
        .in_valid   (hit_valid),
        .in_pixel   (hit_pixel),
        .in_code    (hit_code),
        .in_ready   (hit_ready),
        .out_valid  (bin_valid),
        .out_ready  (bin_ready),
        .out_hit    (bin_hit),
        .drop_count (drop_count)
    );

    hit_fifo fifo_i (
        .clk        (clk),
        .combin_res (combin_res),
        .in_valid   (bin_valid),
        .in_ready   (bin_ready),
        .in_hit     (bin_hit),
        .out_valid  (fifo_valid),
        .out_ready  (fifo_ready),
        .out_hit    (fifo_hit)
    );

    hist_builder builder_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .in_valid    (fifo_valid),
        .in_ready    (fifo_ready),
        .in_hit      (fifo_hit),
        .frame_ready (frame_ready),
        .frame_ack   (frame_ack),
        .rd_pixel    (rd_pixel),
        .rd_bin      (rd_bin),
        .rd_count    (rd_count)
    );

endmodule

`default_nettype wire

/* tests/hist_tb_tasks.svh */
`ifndef HIST_TB_TASKS_SVH
`define HIST_TB_TASKS_SVH

// reference histograms, a few frames deep so the sender can run ahead
localparam int ref_slots = 4;
int ref_count [ref_slots][hist_pkg::entry_num];
// in-window hits sent so far, picks the frame of each hit
int inwin_total;
int ref_drops;
// frames already compared
int frames_read;

// predict one hit from the window and bin rules
function automatic void model_hit(input int pixel, input int code);
    int slot;
    int addr;
    slot = (inwin_total / hist_pkg::events_per_frame) % ref_slots;
    if (code < hist_pkg::tdc_offset
            || code >= hist_pkg::tdc_offset + (hist_pkg::bin_num << hist_pkg::bin_shift)) begin
        ref_drops++;
    end else begin
        // first hit of a frame starts from an empty histogram
        if (inwin_total % hist_pkg::events_per_frame == 0) begin
            for (int a = 0; a < hist_pkg::entry_num; a++) begin
                ref_count[slot][a] = 0;
            end
        end
        addr = pixel * hist_pkg::bin_num + ((code - hist_pkg::tdc_offset) >> hist_pkg::bin_shift);
        // counts stick at 255
        if (ref_count[slot][addr] < 255) begin
            ref_count[slot][addr]++;
        end
        inwin_total++;
    end
endfunction

// valid held until hit_ready seen, returns on the falling edge after the transfer
task automatic send_hit(input int pixel, input int code);
    bit done;
    hit_valid = 1'b1;
    hit_pixel = hist_pkg::pixel_width'(pixel);
    hit_code = hist_pkg::tdc_width'(code);
    done = 1'b0;
    while (!done) begin
        // ready only moves on rising edges
        #1;
        done = hit_ready;
        if (!hit_ready) begin
            saw_stall = 1'b1;
        end
        @(negedge clk);
    end
    model_hit(pixel, code);
endtask

// any pixel, any in-window code
task automatic send_random_hit();
    send_hit(int'($urandom % hist_pkg::pixel_num),
        hist_pkg::tdc_offset + int'($urandom % (hist_pkg::bin_num << hist_pkg::bin_shift)));
endtask

// only pixel 1 bins 2 and 9, pixel 3 bin 15
task automatic send_few_hit(input int i);
    int entry_bin;
    entry_bin = (i % 3 == 0) ? 2 : ((i % 3 == 1) ? 9 : 15);
    send_hit((i % 3 == 2) ? 3 : 1,
        hist_pkg::tdc_offset + (entry_bin << hist_pkg::bin_shift) + i % 8);
endtask

// registered readout, sampled one falling edge after the address
task automatic read_entry(input int pixel, input int bin, output int count);
    rd_pixel = hist_pkg::pixel_width'(pixel);
    rd_bin = hist_pkg::bin_width'(bin);
    @(negedge clk);
    count = int'(rd_count);
endtask

// walk the held bank against the oldest unchecked reference frame
task automatic check_frame();
    int slot;
    int count;
    slot = frames_read % ref_slots;
    for (int p = 0; p < hist_pkg::pixel_num; p++) begin
        for (int b = 0; b < hist_pkg::bin_num; b++) begin
            read_entry(p, b, count);
            check_value($sformatf("pixel %0d bin %0d", p, b),
                ref_count[slot][p * hist_pkg::bin_num + b], count);
        end
    end
    frames_read++;
endtask

`endif

/* tests/hist_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module hist_tb;

    // hits over all tests, sizes the watchdog
    localparam int planned_hits = 300 + 362 + 300 + 750 + 150;
    // about four cycles per hit plus readout and swap margin
    localparam int watchdog_cycles = planned_hits * 4 + 1000;

    logic                             clk;
    logic                             combin_res;
    logic                             hit_valid;
    logic                             hit_ready;
    logic [hist_pkg::pixel_width-1:0] hit_pixel;
    logic [hist_pkg::tdc_width-1:0]   hit_code;
    logic [hist_pkg::drop_width-1:0]  drop_count;
    logic                             frame_ready;
    logic                             frame_ack;
    logic [hist_pkg::pixel_width-1:0] rd_pixel;
    logic [hist_pkg::bin_width-1:0]   rd_bin;
    logic [hist_pkg::count_width-1:0] rd_count;

    int    errors;
    int    checks;
    int    tests;
    int    failed_tests;
    // error count when the current test began
    int    test_errors;
    string cur_test;
    // hit_ready seen low by the sender
    bit    saw_stall;

    `include "hist_tb_tasks.svh"

    hist_top dut_i (.*);

    // 8 ns period
    always #4 clk = ~clk;

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                cur_test, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // swap latency varies, frame_ready marks its end
    task automatic wait_frame();
        int n;
        n = 0;
        while (!frame_ready && n < 1000) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (frame_ready) else begin
            errors++;
            $display("%s: frame_ready did not rise within %0d cycles", cur_test, n);
        end
    endtask

    task automatic close_frame();
        hit_valid = 1'b0;
        wait_frame();
        check_frame();
    endtask

    // one cycle pulse, frame_ready drops on that edge
    task automatic ack_frame();
        frame_ack = 1'b1;
        @(negedge clk);
        frame_ack = 1'b0;
        check_value("frame_ready after ack", 0, int'(frame_ready));
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run did not end within %0d cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int code;
        int n;
        clk = 1'b0;
        combin_res = 1'b0;
        hit_valid = 1'b0;
        hit_pixel = '0;
        hit_code = '0;
        frame_ack = 1'b0;
        rd_pixel = '0;
        rd_bin = '0;
        void'($urandom(46563));
        repeat (2) @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);

        start_test("reset_state");
        check_value("hit_ready", 1, int'(hit_ready));
        check_value("frame_ready", 0, int'(frame_ready));
        check_value("drop_count", 0, int'(drop_count));
        end_test();

        start_test("random_frame");
        repeat (hist_pkg::events_per_frame) send_random_hit();
        close_frame();
        ack_frame();
        end_test();

        // window edges first, then every fifth hit outside
        start_test("window");
        send_hit(0, 31);
        send_hit(1, 160);
        for (int i = 0; i < hist_pkg::events_per_frame; i++) begin
            if (i % 5 == 0) begin
                code = (i % 10 == 0) ? int'($urandom % 32) : 160 + int'($urandom % 96);
                send_hit(int'($urandom % 4), code);
            end
            code = (i == 0) ? 32 : ((i == 1) ? 159 : 32 + int'($urandom % 128));
            send_hit(int'($urandom % 4), code);
        end
        close_frame();
        check_value("drop_count", ref_drops, int'(drop_count));
        ack_frame();
        end_test();

        // pixel 2 bin 5, 300 hits into one 8 bit count
        start_test("saturation");
        repeat (hist_pkg::events_per_frame) send_hit(2, hist_pkg::tdc_offset + (5 << 3) + 3);
        close_frame();
        read_entry(2, 5, n);
        check_value("saturated entry", 255, n);
        ack_frame();
        end_test();

        // second frame completes while the first is still held
        start_test("back_pressure");
        saw_stall = 1'b0;
        fork
            begin
                repeat (2 * hist_pkg::events_per_frame) send_random_hit();
                // half frame, completed by bank_reuse
                for (int i = 0; i < hist_pkg::events_per_frame / 2; i++) begin
                    send_few_hit(i);
                end
                hit_valid = 1'b0;
            end
            begin
                wait_frame();
                check_frame();
                n = 0;
                while (!saw_stall && n < 1000) begin
                    @(negedge clk);
                    n++;
                end
                checks++;
                assert (saw_stall) else begin
                    errors++;
                    $display("%s: hit_ready never went low while a frame was held", cur_test);
                end
                ack_frame();
                wait_frame();
                check_frame();
                ack_frame();
            end
        join
        end_test();

        // lands in the bank that held a random frame
        start_test("bank_reuse");
        for (int i = hist_pkg::events_per_frame / 2; i < hist_pkg::events_per_frame; i++) begin
            send_few_hit(i);
        end
        close_frame();
        ack_frame();
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+tests
src/hist_pkg.sv
src/tdc_binner.sv
src/hit_fifo.sv
src/hist_builder.sv
src/hist_top.sv
tests/hist_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the histogram testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module hist_tb -o hist_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/hist_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only when the testbench printed its pass line
if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
